//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_core
RTL_TOP    := core_top
FILELIST   := src.f
FLAGS      := --timing --assert -Ihdl
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') $(wildcard hdl/*.svh)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of the integer registers and the data path.
`define CORE_XLEN 64

// Address of the first instruction fetched after reset.
`define CORE_RESET_PC 64'h0

// Number of architectural registers, x0 included.
`define CORE_NREGS 32

`endif

//--- hdl/core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst,
    output logic [`CORE_XLEN-1:0]   inst_addr,
    input  logic [31:0]             inst_data,
    output logic [`CORE_XLEN-1:0]   data_addr,
    output logic [`CORE_XLEN-1:0]   data_wdata,
    output logic [`CORE_XLEN/8-1:0] data_wmask,
    output logic                    data_wen,
    output logic                    data_ren,
    input  logic [`CORE_XLEN-1:0]   data_rdata
);

    logic [`CORE_XLEN-1:0]          if_pc, id_pc, ex_pc;
    logic [31:0]                    if_inst, id_inst, ex_inst;
    logic                           if_valid, id_valid, ex_valid, mem_valid, stall;
    pipe_pkg::alu_op_e              id_alu_op, ex_alu_op;
    logic [`CORE_XLEN-1:0]          id_alu_src1, id_alu_src2, id_rf_rdata2;
    logic [`CORE_XLEN-1:0]          ex_alu_src1, ex_alu_src2, ex_rf_rdata2;
    logic                           id_mem_wen, id_mem_ren, ex_mem_wen, ex_mem_ren;
    pipe_pkg::mem_size_e            id_mem_size, ex_mem_size;
    pipe_pkg::wb_sel_e              id_wb_sel, ex_wb_sel, mem_wb_sel;
    logic                           id_rf_we, ex_rf_we, mem_rf_we, wb_we;
    logic [$clog2(`CORE_NREGS)-1:0] id_rf_waddr, ex_rf_waddr, mem_rf_waddr, wb_addr;
    logic [`CORE_XLEN-1:0]          mem_alu_res, mem_wdata, wb_data;
    logic [`CORE_XLEN/8-1:0]        mem_wmask;
    logic                           mem_wen, mem_ren;

    // Every stage port carries the name of the wire it connects to.
    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*);

    id_ex_reg u_id_ex (
        .ena    (1'b1),
        .bubble (stall), // Stalled decode sends a bubble down the pipe.
        .*
    );

    execute_stage u_execute (.*);

    mem_wb_stage u_mem_wb (.*);

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`CORE_XLEN-1:0]          if_pc,
    input  logic [31:0]                    if_inst,
    input  logic                           if_valid,
    input  logic                           wb_we,
    input  logic [$clog2(`CORE_NREGS)-1:0] wb_addr,
    input  logic [`CORE_XLEN-1:0]          wb_data,
    input  logic                           ex_rf_we,
    input  logic [$clog2(`CORE_NREGS)-1:0] ex_rf_waddr,
    input  logic                           ex_valid,
    input  logic                           mem_rf_we,
    input  logic [$clog2(`CORE_NREGS)-1:0] mem_rf_waddr,
    input  logic                           mem_valid,
    output logic                           stall,
    output logic [`CORE_XLEN-1:0]          id_pc,
    output logic [31:0]                    id_inst,
    output pipe_pkg::alu_op_e              id_alu_op,
    output logic [`CORE_XLEN-1:0]          id_alu_src1,
    output logic [`CORE_XLEN-1:0]          id_alu_src2,
    output logic [`CORE_XLEN-1:0]          id_rf_rdata2,
    output logic                           id_mem_wen,
    output logic                           id_mem_ren,
    output pipe_pkg::mem_size_e            id_mem_size,
    output pipe_pkg::wb_sel_e              id_wb_sel,
    output logic                           id_rf_we,
    output logic [$clog2(`CORE_NREGS)-1:0] id_rf_waddr,
    output logic                           id_valid
);

    logic [`CORE_XLEN-1:0]          regs [`CORE_NREGS];
    logic [`CORE_XLEN-1:0]          rdata1, rdata2, imm_i, imm_s, imm_u;
    logic [$clog2(`CORE_NREGS)-1:0] rs1, rs2, rd;
    isa_pkg::opcode_e               opcode;
    isa_pkg::funct3_e               funct3;
    isa_pkg::funct7_e               funct7;
    logic                           use_rs1, use_rs2, writes_rd, r_legal;
    logic                           hit_rs1, hit_rs2;

    assign opcode = isa_pkg::opcode_e'(if_inst[6:0]);
    assign funct3 = isa_pkg::funct3_e'(if_inst[14:12]);
    assign funct7 = isa_pkg::funct7_e'(if_inst[31:25]);
    assign rd     = if_inst[11:7];
    assign rs1    = if_inst[19:15];
    assign rs2    = if_inst[24:20];
    assign imm_i  = {{(`CORE_XLEN-12){if_inst[31]}}, if_inst[31:20]};
    assign imm_s  = {{(`CORE_XLEN-12){if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_u  = {{(`CORE_XLEN-32){if_inst[31]}}, if_inst[31:12], 12'h000};

    // SUB and SRA are the only alternate encodings in the subset.
    assign r_legal = funct7 == isa_pkg::F7_BASE || (funct7 == isa_pkg::F7_ALT &&
                     (funct3 == isa_pkg::F3_ADD || funct3 == isa_pkg::F3_SR));

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // A write in this cycle is visible to the instruction being decoded.
    assign rdata1 = (rs1 == '0) ? '0 : (wb_we && wb_addr == rs1) ? wb_data : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (wb_we && wb_addr == rs2) ? wb_data : regs[rs2];

    always_comb begin
        id_alu_op   = pipe_pkg::ALU_ADD;
        id_alu_src1 = rdata1;
        id_alu_src2 = rdata2;
        id_mem_wen  = 1'b0;
        id_mem_ren  = 1'b0;
        id_mem_size = pipe_pkg::SIZE_DOUBLE;
        id_wb_sel   = pipe_pkg::WB_ALU;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        writes_rd   = 1'b0;
        case (opcode)
            isa_pkg::OPC_OP: begin
                if (r_legal) begin
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    writes_rd = 1'b1;
                    case (funct3)
                        isa_pkg::F3_ADD: id_alu_op = if_inst[30] ? pipe_pkg::ALU_SUB
                                                                 : pipe_pkg::ALU_ADD;
                        isa_pkg::F3_SLL: id_alu_op = pipe_pkg::ALU_SLL;
                        isa_pkg::F3_SLT: id_alu_op = pipe_pkg::ALU_SLT;
                        isa_pkg::F3_SLTU: id_alu_op = pipe_pkg::ALU_SLTU;
                        isa_pkg::F3_XOR: id_alu_op = pipe_pkg::ALU_XOR;
                        isa_pkg::F3_SR: id_alu_op = if_inst[30] ? pipe_pkg::ALU_SRA
                                                                : pipe_pkg::ALU_SRL;
                        isa_pkg::F3_OR: id_alu_op = pipe_pkg::ALU_OR;
                        default: id_alu_op = pipe_pkg::ALU_AND;
                    endcase
                end
            end
            isa_pkg::OPC_OP_IMM: begin
                if (funct3 == isa_pkg::F3_ADD) begin // Only ADDI is decoded.
                    use_rs1     = 1'b1;
                    writes_rd   = 1'b1;
                    id_alu_src2 = imm_i;
                end
            end
            isa_pkg::OPC_LUI: begin
                writes_rd   = 1'b1;
                id_alu_op   = pipe_pkg::ALU_PASS_B;
                id_alu_src1 = '0;
                id_alu_src2 = imm_u;
            end
            isa_pkg::OPC_LOAD: begin
                if (if_inst[14:12] == isa_pkg::W_DOUBLE) begin
                    use_rs1     = 1'b1;
                    writes_rd   = 1'b1;
                    id_alu_src2 = imm_i;
                    id_mem_ren  = 1'b1;
                    id_wb_sel   = pipe_pkg::WB_MEM;
                end
            end
            isa_pkg::OPC_STORE: begin
                if (!if_inst[14]) begin
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                    id_alu_src2 = imm_s;
                    id_mem_wen  = 1'b1;
                    id_mem_size = pipe_pkg::mem_size_e'(if_inst[13:12]);
                end
            end
            default: ;
        endcase
    end

    assign id_pc        = if_pc;
    assign id_inst      = if_inst;
    assign id_rf_rdata2 = rdata2;
    assign id_rf_we     = writes_rd && rd != '0;
    assign id_rf_waddr  = rd;
    assign id_valid     = if_valid;

    assign hit_rs1 = use_rs1 && rs1 != '0 &&
                     ((ex_valid && ex_rf_we && ex_rf_waddr == rs1) ||
                      (mem_valid && mem_rf_we && mem_rf_waddr == rs1));
    assign hit_rs2 = use_rs2 && rs2 != '0 &&
                     ((ex_valid && ex_rf_we && ex_rf_waddr == rs2) ||
                      (mem_valid && mem_rf_we && mem_rf_waddr == rs2));
    assign stall   = if_valid && (hit_rs1 || hit_rs2);

    // The write enable travels through three pipeline registers before it gets here.
    a_no_x0_write : assert property (@(posedge clk) disable iff (rst) wb_we |-> wb_addr != '0)
        else $error("register x0 written with %h", wb_data);

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`CORE_XLEN-1:0]          ex_pc,
    input  logic [31:0]                    ex_inst,
    input  pipe_pkg::alu_op_e              ex_alu_op,
    input  logic [`CORE_XLEN-1:0]          ex_alu_src1,
    input  logic [`CORE_XLEN-1:0]          ex_alu_src2,
    input  logic [`CORE_XLEN-1:0]          ex_rf_rdata2,
    input  logic                           ex_mem_wen,
    input  logic                           ex_mem_ren,
    input  pipe_pkg::mem_size_e            ex_mem_size,
    input  pipe_pkg::wb_sel_e              ex_wb_sel,
    input  logic                           ex_rf_we,
    input  logic [$clog2(`CORE_NREGS)-1:0] ex_rf_waddr,
    input  logic                           ex_valid,
    output logic [`CORE_XLEN-1:0]          mem_alu_res,
    output logic [`CORE_XLEN-1:0]          mem_wdata,
    output logic [`CORE_XLEN/8-1:0]        mem_wmask,
    output logic                           mem_wen,
    output logic                           mem_ren,
    output pipe_pkg::wb_sel_e              mem_wb_sel,
    output logic                           mem_rf_we,
    output logic [$clog2(`CORE_NREGS)-1:0] mem_rf_waddr,
    output logic                           mem_valid
);

    logic [`CORE_XLEN-1:0]   alu_res;
    logic [5:0]              shamt;
    logic [2:0]              offset, align;
    logic [`CORE_XLEN/8-1:0] base_mask;

    assign shamt  = ex_alu_src2[5:0];
    assign offset = alu_res[2:0];

    always_comb begin
        case (ex_alu_op)
            pipe_pkg::ALU_ADD: alu_res = ex_alu_src1 + ex_alu_src2;
            pipe_pkg::ALU_SUB: alu_res = ex_alu_src1 - ex_alu_src2;
            pipe_pkg::ALU_AND: alu_res = ex_alu_src1 & ex_alu_src2;
            pipe_pkg::ALU_OR: alu_res = ex_alu_src1 | ex_alu_src2;
            pipe_pkg::ALU_XOR: alu_res = ex_alu_src1 ^ ex_alu_src2;
            pipe_pkg::ALU_SLL: alu_res = ex_alu_src1 << shamt;
            pipe_pkg::ALU_SRL: alu_res = ex_alu_src1 >> shamt;
            pipe_pkg::ALU_SRA: alu_res = $signed(ex_alu_src1) >>> shamt;
            pipe_pkg::ALU_SLT:
                alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(ex_alu_src1) < $signed(ex_alu_src2)};
            pipe_pkg::ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, ex_alu_src1 < ex_alu_src2};
            default: alu_res = ex_alu_src2;
        endcase
    end

    always_comb begin
        case (ex_mem_size)
            pipe_pkg::SIZE_BYTE: {base_mask, align} = {8'h01, 3'b000};
            pipe_pkg::SIZE_HALF: {base_mask, align} = {8'h03, 3'b001};
            pipe_pkg::SIZE_WORD: {base_mask, align} = {8'h0f, 3'b011};
            default: {base_mask, align} = {8'hff, 3'b111};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wen   <= 1'b0;
            mem_ren   <= 1'b0;
            mem_rf_we <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            mem_wen   <= ex_mem_wen;
            mem_ren   <= ex_mem_ren;
            mem_rf_we <= ex_rf_we;
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_res  <= alu_res;
        mem_wdata    <= ex_rf_rdata2 << {offset, 3'b000}; // Move data into its byte lanes.
        mem_wmask    <= ex_mem_wen ? base_mask << offset : '0;
        mem_wb_sel   <= ex_wb_sel;
        mem_rf_waddr <= ex_rf_waddr;
    end

    a_store_aligned : assert property (@(posedge clk) disable iff (rst)
        ex_valid && ex_mem_wen |-> (offset & align) == 3'b000)
        else $error("misaligned store %h at pc %h, address %h", ex_inst, ex_pc, alu_res);

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    output logic [`CORE_XLEN-1:0] inst_addr,
    input  logic [31:0]           inst_data,
    output logic [`CORE_XLEN-1:0] if_pc,
    output logic [31:0]           if_inst,
    output logic                  if_valid
);

    localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

    logic [`CORE_XLEN-1:0] pc;

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `CORE_RESET_PC;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + PC_STEP;
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc   <= pc;
            if_inst <= inst_data; // Held while decode waits on a hazard.
        end
    end

    a_pc_aligned : assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("fetch PC %h is not word aligned", pc);

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module id_ex_reg (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ena,
    input  logic                           bubble,
    input  logic [`CORE_XLEN-1:0]          id_pc,
    input  logic [31:0]                    id_inst,
    input  pipe_pkg::alu_op_e              id_alu_op,
    input  logic [`CORE_XLEN-1:0]          id_alu_src1,
    input  logic [`CORE_XLEN-1:0]          id_alu_src2,
    input  logic [`CORE_XLEN-1:0]          id_rf_rdata2,
    input  logic                           id_mem_wen,
    input  logic                           id_mem_ren,
    input  pipe_pkg::mem_size_e            id_mem_size,
    input  pipe_pkg::wb_sel_e              id_wb_sel,
    input  logic                           id_rf_we,
    input  logic [$clog2(`CORE_NREGS)-1:0] id_rf_waddr,
    input  logic                           id_valid,
    output logic [`CORE_XLEN-1:0]          ex_pc,
    output logic [31:0]                    ex_inst,
    output pipe_pkg::alu_op_e              ex_alu_op,
    output logic [`CORE_XLEN-1:0]          ex_alu_src1,
    output logic [`CORE_XLEN-1:0]          ex_alu_src2,
    output logic [`CORE_XLEN-1:0]          ex_rf_rdata2,
    output logic                           ex_mem_wen,
    output logic                           ex_mem_ren,
    output pipe_pkg::mem_size_e            ex_mem_size,
    output pipe_pkg::wb_sel_e              ex_wb_sel,
    output logic                           ex_rf_we,
    output logic [$clog2(`CORE_NREGS)-1:0] ex_rf_waddr,
    output logic                           ex_valid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_pc        <= `CORE_RESET_PC - 4;
            ex_inst      <= '0;
            ex_alu_op    <= pipe_pkg::ALU_ADD;
            ex_alu_src1  <= '0;
            ex_alu_src2  <= '0;
            ex_rf_rdata2 <= '0;
            ex_mem_wen   <= 1'b0;
            ex_mem_ren   <= 1'b0;
            ex_mem_size  <= pipe_pkg::SIZE_DOUBLE;
            ex_wb_sel    <= pipe_pkg::WB_ALU;
            ex_rf_we     <= 1'b0;
            ex_rf_waddr  <= '0;
            ex_valid     <= 1'b0;
        end else if (ena) begin
            ex_pc        <= id_pc;
            ex_inst      <= id_inst;
            ex_alu_op    <= id_alu_op;
            ex_alu_src1  <= id_alu_src1;
            ex_alu_src2  <= id_alu_src2;
            ex_rf_rdata2 <= id_rf_rdata2;
            ex_mem_size  <= id_mem_size;
            ex_wb_sel    <= id_wb_sel;
            ex_rf_waddr  <= id_rf_waddr;
            ex_mem_wen   <= id_mem_wen && !bubble; // A bubble carries no side effects.
            ex_mem_ren   <= id_mem_ren && !bubble;
            ex_rf_we     <= id_rf_we && !bubble;
            ex_valid     <= id_valid && !bubble;
        end
    end

endmodule

//--- hdl/isa_pkg.sv
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000, // ADD, SUB and ADDI.
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101, // SRL and SRA.
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // Access width carried in funct3 of loads and stores.
    typedef enum logic [2:0] {
        W_BYTE   = 3'b000,
        W_HALF   = 3'b001,
        W_WORD   = 3'b010,
        W_DOUBLE = 3'b011
    } width_e;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000 // Selects SUB and SRA.
    } funct7_e;

endpackage

//--- hdl/mem_wb_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module mem_wb_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`CORE_XLEN-1:0]          mem_alu_res,
    input  logic [`CORE_XLEN-1:0]          mem_wdata,
    input  logic [`CORE_XLEN/8-1:0]        mem_wmask,
    input  logic                           mem_wen,
    input  logic                           mem_ren,
    input  pipe_pkg::wb_sel_e              mem_wb_sel,
    input  logic                           mem_rf_we,
    input  logic [$clog2(`CORE_NREGS)-1:0] mem_rf_waddr,
    input  logic                           mem_valid,
    output logic [`CORE_XLEN-1:0]          data_addr,
    output logic [`CORE_XLEN-1:0]          data_wdata,
    output logic [`CORE_XLEN/8-1:0]        data_wmask,
    output logic                           data_wen,
    output logic                           data_ren,
    input  logic [`CORE_XLEN-1:0]          data_rdata,
    output logic                           wb_we,
    output logic [$clog2(`CORE_NREGS)-1:0] wb_addr,
    output logic [`CORE_XLEN-1:0]          wb_data
);

    logic [`CORE_XLEN-1:0] result;

    assign data_addr  = mem_alu_res;
    assign data_wdata = mem_wdata;
    assign data_wen   = mem_valid && mem_wen;
    assign data_ren   = mem_valid && mem_ren;
    assign data_wmask = data_wen ? mem_wmask : '0; // No lanes are active without a store.

    // The data port answers in the same cycle, so the load word is ready here.
    assign result = (mem_wb_sel == pipe_pkg::WB_MEM) ? data_rdata : mem_alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_valid && mem_rf_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= mem_rf_waddr;
        wb_data <= result;
    end

endmodule

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B // Used by LUI.
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    // Encoded as the low two bits of the store funct3.
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD,
        SIZE_DOUBLE
    } mem_size_e;

endpackage

//--- src.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/id_ex_reg.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/core_top.sv
verif/tb_core.sv

//--- verif/tb_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;

    localparam int NROWS     = 15;
    localparam int NSTORES   = NROWS + 2;
    localparam int NLOADS    = 2 * NROWS;
    localparam int DWORDS    = 512;
    localparam int IWORDS    = 256;
    localparam int OPND_BASE = 'h100;
    localparam int RES_BASE  = 'h400;
    localparam int WD_CYCLES = NSTORES * 4 * 3 + 50;
    localparam logic [31:0] NOP = 32'h00000013;

    logic                    clk;
    logic                    rst;
    logic [`CORE_XLEN-1:0]   inst_addr;
    logic [31:0]             inst_data;
    logic [`CORE_XLEN-1:0]   data_addr;
    logic [`CORE_XLEN-1:0]   data_wdata;
    logic [`CORE_XLEN/8-1:0] data_wmask;
    logic                    data_wen;
    logic                    data_ren;
    logic [`CORE_XLEN-1:0]   data_rdata;

    logic [31:0]           imem [IWORDS];
    logic [`CORE_XLEN-1:0] dmem [DWORDS];

    // The test table holds one row per ALU block.
    pipe_pkg::alu_op_e   t_op   [NROWS];
    logic [63:0]         t_a    [NROWS];
    logic [63:0]         t_b    [NROWS];
    pipe_pkg::mem_size_e t_size [NROWS];
    logic [2:0]          t_off  [NROWS];
    logic [63:0]         t_data [NROWS];
    logic [7:0]          t_mask [NROWS];
    bit                  t_rand [NROWS];

    logic [63:0] exp_addr [NSTORES];
    logic [63:0] exp_data [NSTORES];
    logic [7:0]  exp_mask [NSTORES];

    int          nrows_set;
    int          store_count;
    int          load_count;
    int          errors;
    logic [31:0] lfsr;

    core_top UUT (.*);

    always #20 clk = ~clk;

    assign inst_data  = (inst_addr < IWORDS * 4) ? imem[inst_addr[9:2]] : NOP;
    assign data_rdata = dmem[data_addr[11:3]];

    function automatic logic [63:0] fill_word(input int idx);
        return {32'ha5c30000 ^ idx, 32'h3c000000 ^ (idx * 7 + 1)};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h80200003;
        end
        return s;
    endfunction

    function automatic logic [63:0] rand64();
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < 64; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input pipe_pkg::alu_op_e op, input logic [4:0] rd);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = isa_pkg::F7_BASE;
        case (op)
            pipe_pkg::ALU_SUB: {f3, f7} = {isa_pkg::F3_ADD, isa_pkg::F7_ALT};
            pipe_pkg::ALU_AND: f3 = isa_pkg::F3_AND;
            pipe_pkg::ALU_OR: f3 = isa_pkg::F3_OR;
            pipe_pkg::ALU_XOR: f3 = isa_pkg::F3_XOR;
            pipe_pkg::ALU_SLL: f3 = isa_pkg::F3_SLL;
            pipe_pkg::ALU_SRL: f3 = isa_pkg::F3_SR;
            pipe_pkg::ALU_SRA: {f3, f7} = {isa_pkg::F3_SR, isa_pkg::F7_ALT};
            pipe_pkg::ALU_SLT: f3 = isa_pkg::F3_SLT;
            pipe_pkg::ALU_SLTU: f3 = isa_pkg::F3_SLTU;
            default: f3 = isa_pkg::F3_ADD;
        endcase
        return {f7, 5'd2, 5'd1, f3, rd, isa_pkg::OPC_OP}; // Always rd = x1 op x2.
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], isa_pkg::OPC_STORE};
    endfunction

    task automatic add_row(input pipe_pkg::alu_op_e op, input logic [63:0] a, b,
                           input pipe_pkg::mem_size_e size, input logic [2:0] off,
                           input logic [63:0] data, input logic [7:0] mask, input bit rnd);
        t_op[nrows_set]   = op;
        t_a[nrows_set]    = a;
        t_b[nrows_set]    = b;
        t_size[nrows_set] = size;
        t_off[nrows_set]  = off;
        t_data[nrows_set] = data;
        t_mask[nrows_set] = mask;
        t_rand[nrows_set] = rnd;
        nrows_set++;
    endtask

    task automatic build_table();
        add_row(pipe_pkg::ALU_ADD, 64'd5, 64'd7, pipe_pkg::SIZE_DOUBLE, 0, 64'hc, 8'hff, 0);
        add_row(pipe_pkg::ALU_SUB, 64'd3, 64'd5, pipe_pkg::SIZE_DOUBLE, 0,
                64'hffff_ffff_ffff_fffe, 8'hff, 0);
        add_row(pipe_pkg::ALU_AND, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0,
                pipe_pkg::SIZE_DOUBLE, 0, 64'h0f00_0f00_0f00_0f00, 8'hff, 0);
        add_row(pipe_pkg::ALU_OR, 64'hf0, 64'h0f, pipe_pkg::SIZE_DOUBLE, 0, 64'hff, 8'hff, 0);
        add_row(pipe_pkg::ALU_XOR, 64'haaaa, 64'hffff, pipe_pkg::SIZE_DOUBLE, 0, 64'h5555,
                8'hff, 0);
        // Only the low six bits of the shift amount count.
        add_row(pipe_pkg::ALU_SLL, 64'd1, 64'h43, pipe_pkg::SIZE_DOUBLE, 0, 64'h8, 8'hff, 0);
        add_row(pipe_pkg::ALU_SRL, 64'h8000_0000_0000_0000, 64'd4, pipe_pkg::SIZE_DOUBLE, 0,
                64'h0800_0000_0000_0000, 8'hff, 0);
        add_row(pipe_pkg::ALU_SRA, 64'h8000_0000_0000_0000, 64'd4, pipe_pkg::SIZE_DOUBLE, 0,
                64'hf800_0000_0000_0000, 8'hff, 0);
        add_row(pipe_pkg::ALU_SLT, '1, 64'd1, pipe_pkg::SIZE_DOUBLE, 0, 64'h1, 8'hff, 0);
        add_row(pipe_pkg::ALU_SLTU, '1, 64'd1, pipe_pkg::SIZE_DOUBLE, 0, 64'h0, 8'hff, 0);
        add_row(pipe_pkg::ALU_ADD, 64'h11, 64'h22, pipe_pkg::SIZE_BYTE, 3, 64'h3300_0000,
                8'h08, 0);
        add_row(pipe_pkg::ALU_XOR, 64'h1234, 64'h0, pipe_pkg::SIZE_HALF, 2, 64'h1234_0000,
                8'h0c, 0);
        add_row(pipe_pkg::ALU_OR, 64'hdead_beef, 64'h0, pipe_pkg::SIZE_WORD, 4,
                64'hdead_beef_0000_0000, 8'hf0, 0);
        add_row(pipe_pkg::ALU_ADD, 0, 0, pipe_pkg::SIZE_DOUBLE, 0, 0, 8'hff, 1);
        add_row(pipe_pkg::ALU_XOR, 0, 0, pipe_pkg::SIZE_DOUBLE, 0, 0, 8'hff, 1);
    endtask

    task automatic assemble();
        int pc;
        int slot;
        pc = 0;
        for (int r = 0; r < NROWS; r++) begin
            if (t_rand[r]) begin
                t_a[r] = rand64();
                t_b[r] = rand64();
                t_data[r] = (t_op[r] == pipe_pkg::ALU_ADD) ? t_a[r] + t_b[r] : t_a[r] ^ t_b[r];
            end
            dmem[(OPND_BASE >> 3) + 2 * r]     = t_a[r];
            dmem[(OPND_BASE >> 3) + 2 * r + 1] = t_b[r];
            slot = RES_BASE + 8 * r + t_off[r];
            imem[pc++] = enc_i(OPND_BASE + 16 * r, 0, isa_pkg::W_DOUBLE, 1, isa_pkg::OPC_LOAD);
            imem[pc++] = enc_i(OPND_BASE + 16 * r + 8, 0, isa_pkg::W_DOUBLE, 2,
                               isa_pkg::OPC_LOAD);
            imem[pc++] = enc_r(t_op[r], 3);
            imem[pc++] = enc_s(slot, 3, {1'b0, t_size[r]});
            exp_addr[r] = slot;
            exp_data[r] = t_data[r];
            exp_mask[r] = t_mask[r];
        end
        // Three dependent ADDI with the negative immediates -5, -3 and -8.
        imem[pc++] = enc_i(-12'sd5, 0, isa_pkg::F3_ADD, 4, isa_pkg::OPC_OP_IMM);
        imem[pc++] = enc_i(-12'sd3, 4, isa_pkg::F3_ADD, 4, isa_pkg::OPC_OP_IMM);
        imem[pc++] = enc_i(-12'sd8, 4, isa_pkg::F3_ADD, 4, isa_pkg::OPC_OP_IMM);
        imem[pc++] = enc_s(RES_BASE + 8 * NROWS, 4, isa_pkg::W_DOUBLE);
        exp_addr[NROWS] = RES_BASE + 8 * NROWS;
        exp_data[NROWS] = 64'hffff_ffff_ffff_fff0;
        exp_mask[NROWS] = 8'hff;
        imem[pc++] = {20'h80000, 5'd6, isa_pkg::OPC_LUI};
        imem[pc++] = enc_s(RES_BASE + 8 * (NROWS + 1), 6, isa_pkg::W_DOUBLE);
        exp_addr[NROWS + 1] = RES_BASE + 8 * (NROWS + 1);
        exp_data[NROWS + 1] = 64'hffff_ffff_8000_0000;
        exp_mask[NROWS + 1] = 8'hff;
    endtask

    task automatic check_store();
        if (store_count >= NSTORES) begin
            $display("Unexpected extra store to address %h", data_addr);
            errors++;
        end else begin
            if (data_addr !== exp_addr[store_count]) begin
                $display("MISMATCH store %0d data_addr: got %h expected %h", store_count,
                         data_addr, exp_addr[store_count]);
                errors++;
            end
            if (data_wdata !== exp_data[store_count]) begin
                $display("MISMATCH store %0d data_wdata: got %h expected %h", store_count,
                         data_wdata, exp_data[store_count]);
                errors++;
            end
            if (data_wmask !== exp_mask[store_count]) begin
                $display("MISMATCH store %0d data_wmask: got %h expected %h", store_count,
                         data_wmask, exp_mask[store_count]);
                errors++;
            end
        end
        store_count++;
    endtask

    // Loads walk the operand slots in program order, one doubleword each.
    task automatic check_load();
        logic [63:0] want;
        want = OPND_BASE + 8 * load_count;
        if (load_count >= NLOADS) begin
            $display("Unexpected extra load from address %h", data_addr);
            errors++;
        end else if (data_addr !== want) begin
            $display("MISMATCH load %0d data_addr: got %h expected %h", load_count,
                     data_addr, want);
            errors++;
        end
        load_count++;
    endtask

    // The data memory applies byte-masked writes and checks each access as it lands.
    always @(posedge clk) begin
        if (!rst && data_ren) begin
            check_load();
        end
        if (!rst && data_wen) begin
            check_store();
            for (int b = 0; b < 8; b++) begin
                if (data_wmask[b]) begin
                    dmem[data_addr[11:3]][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

    task automatic check_readback();
        int          idx;
        logic [63:0] want;
        for (int s = 0; s < NSTORES; s++) begin
            idx = exp_addr[s][11:3];
            want = fill_word(idx);
            for (int b = 0; b < 8; b++) begin
                if (exp_mask[s][b]) begin
                    want[8*b +: 8] = exp_data[s][8*b +: 8];
                end
            end
            if (dmem[idx] !== want) begin
                $display("MISMATCH read-back word %0d dmem: got %h expected %h", idx,
                         dmem[idx], want);
                errors++;
            end
        end
    endtask

    initial begin
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d stores seen after %0d cycles", store_count,
                 NSTORES, WD_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        lfsr        = 32'h97ec8846;
        nrows_set   = 0;
        store_count = 0;
        load_count  = 0;
        errors      = 0;
        for (int i = 0; i < IWORDS; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < DWORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        build_table();
        assemble();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        if (inst_addr !== `CORE_RESET_PC) begin
            $display("MISMATCH after reset inst_addr: got %h expected %h", inst_addr,
                     `CORE_RESET_PC);
            errors++;
        end
        if (data_wen !== 1'b0 || data_ren !== 1'b0) begin
            $display("MISMATCH after reset data_wen/data_ren: got %h/%h expected 0/0",
                     data_wen, data_ren);
            errors++;
        end
        wait (store_count >= NSTORES);
        repeat (20) @(posedge clk); // Room for a duplicated store to show up.
        if (store_count != NSTORES) begin
            $display("Store count is wrong: saw %0d stores, expected %0d", store_count,
                     NSTORES);
            errors++;
        end
        if (load_count != NLOADS) begin
            $display("Load count is wrong: saw %0d loads, expected %0d", load_count,
                     NLOADS);
            errors++;
        end
        check_readback();
        $display("Run complete with %0d errors over %0d stores and %0d loads", errors,
                 store_count, load_count);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
